//--- usb_ep_buffer.f
hdl/buf_geom_pkg.sv
hdl/usb_pkt_pkg.sv
hdl/usb_dual_port_buffer.sv
hdl/usb_rx_writer.sv
hdl/usb_len_queue.sv
hdl/usb_tx_reader.sv
hdl/usb_ep_buffer_top.sv
test/usb_ep_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the endpoint buffer testbench with Verilator, result taken from sim.log
verilator --binary --assert --top-module usb_ep_buffer_tb -f usb_ep_buffer.f \
    --Mdir obj_dir -o usb_ep_buffer_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/usb_ep_buffer_sim > sim.log 2>&1
grep -q "^Simulation completed successfully$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }

//--- test/usb_ep_buffer_tb.sv
// Random packet testbench. The accept model lags the DUT, so it only waits for room and never over-predicts it
`timescale 1ns/1ns
`default_nettype none

module usb_ep_buffer_tb;

    localparam int SEED        = 71178;
    localparam int N_WRAP      = 12;
    localparam int N_RAND      = 40;
    localparam int N_SHORT     = 8;
    // Every packet of every phase, including drop and overflow packets
    localparam int N_PKTS      = N_WRAP + 3 + N_RAND + 5 + N_SHORT;
    localparam int MAX_GAP     = 6;
    localparam int HOLD_MARGIN = 2000;
    localparam int TIMEOUT_CYCLES =
        N_PKTS * (usb_pkt_pkg::MAX_PKT + MAX_GAP) * 2 + HOLD_MARGIN;

    logic                    clk_a;
    logic                    rst_a;
    logic                    rx_valid;
    buf_geom_pkg::buf_data_t rx_data;
    logic                    rx_last;
    logic                    rx_error;
    logic                    out_hold;
    logic                    out_valid;
    buf_geom_pkg::buf_data_t out_data;
    logic                    out_first;
    logic                    out_last;
    logic                    pkt_drop;

    // Expected output bytes as {first, last, data}
    logic [9:0] exp_q [$];

    // Sender side of the model
    int   bytes_in;
    int   pkts_in;
    int   exp_drops;
    int   ctrl_errs;
    logic hold_random;
    // Output side of the model
    int   bytes_out;
    int   firsts_out;
    int   seen_drops;
    int   data_errs;
    int   marker_errs;
    int   cycles;

    usb_ep_buffer_top DUT (
        .clk_a     (clk_a),
        .rst_a     (rst_a),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_last   (rx_last),
        .rx_error  (rx_error),
        .out_hold  (out_hold),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_first (out_first),
        .out_last  (out_last),
        .pkt_drop  (pkt_drop)
    );

    initial begin
        clk_a = 1'b0;
        forever #2 clk_a = ~clk_a;
    end

    // Writer rule at a first byte: one full packet of free space and a free length slot
    function automatic bit has_room();
        int fill;
        fill = bytes_in - bytes_out;
        return (buf_geom_pkg::DEPTH - fill >= usb_pkt_pkg::MAX_PKT)
            && (pkts_in - firsts_out < usb_pkt_pkg::LEN_SLOTS);
    endfunction

    task automatic next_cycle();
        @(posedge clk_a);
        #1;
        if (hold_random) begin
            out_hold = ($urandom_range(3) == 0);
        end
    endtask

    task automatic idle_gap(input int max_gap);
        repeat ($urandom_range(max_gap)) next_cycle();
    endtask

    task automatic send_packet(input int len, input bit err, input bit wait_room);
        bit                      accept;
        buf_geom_pkg::buf_data_t b;
        if (wait_room) begin
            while (!has_room()) next_cycle();
        end
        accept = has_room() && !err && (len <= usb_pkt_pkg::MAX_PKT);
        for (int i = 0; i < len; i++) begin
            b = buf_geom_pkg::buf_data_t'($urandom);
            if (accept) begin
                exp_q.push_back({i == 0, i == len - 1, b});
            end
            rx_valid = 1'b1;
            rx_data  = b;
            rx_last  = (i == len - 1);
            rx_error = err && (i == len - 1);
            next_cycle();
            rx_valid = 1'b0;
            rx_last  = 1'b0;
            rx_error = 1'b0;
            // Occasional idle cycle inside the packet
            if (i != len - 1 && $urandom_range(3) == 0) begin
                next_cycle();
            end
        end
        if (accept) begin
            bytes_in += len;
            pkts_in  += 1;
        end else begin
            exp_drops += 1;
        end
    endtask

    task automatic drain_output();
        while (exp_q.size() != 0) next_cycle();
        repeat (4) next_cycle();
    endtask

    task automatic check_drops(input string phase);
        assert (seen_drops == exp_drops) else begin
            ctrl_errs++;
            $display("[ERROR] %0t: %s drop pulses %0d, expected %0d",
                     $time, phase, seen_drops, exp_drops);
        end
    endtask

    task automatic check_output();
        logic [9:0] exp;
        if (exp_q.size() == 0) begin
            data_errs++;
            $display("Output byte at %0t arrived while no packet was expected", $time);
        end else begin
            exp = exp_q.pop_front();
            assert (out_data == exp[7:0]) else begin
                data_errs++;
                $display("[ERROR] %0t: out_data %h, expected %h", $time, out_data, exp[7:0]);
            end
            assert ({out_first, out_last} == exp[9:8]) else begin
                marker_errs++;
                $display("[ERROR] %0t: markers first/last %b%b, expected %b",
                         $time, out_first, out_last, exp[9:8]);
            end
        end
        bytes_out++;
        if (out_first) begin
            firsts_out++;
        end
    endtask

    // Outputs change on the rising edge and are sampled on the falling one
    always @(negedge clk_a) begin
        if (!rst_a) begin
            if (pkt_drop) begin
                seen_drops++;
            end
            assert (out_valid || (!out_first && !out_last)) else begin
                marker_errs++;
                $display("[ERROR] %0t: marker raised without out_valid", $time);
            end
            if (out_valid) begin
                check_output();
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_a);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_a       = 1'b1;
        rx_valid    = 1'b0;
        rx_data     = '0;
        rx_last     = 1'b0;
        rx_error    = 1'b0;
        out_hold    = 1'b0;
        hold_random = 1'b0;
        repeat (3) @(posedge clk_a);
        #1 rst_a = 1'b0;

        // Quiet outputs after reset
        repeat (6) begin
            next_cycle();
            assert (!out_valid && !out_first && !out_last && !pkt_drop) else begin
                ctrl_errs++;
                $display("[ERROR] %0t: output active before any input", $time);
            end
        end

        // Clean packets, enough bytes to wrap the pointers
        for (int n = 0; n < N_WRAP; n++) begin
            send_packet(int'($urandom_range(usb_pkt_pkg::MAX_PKT, 1)), 1'b0, 1'b1);
            idle_gap(MAX_GAP);
        end
        drain_output();
        check_drops("wrap");

        // Error packet, oversize packet, then a good one
        send_packet(5, 1'b1, 1'b1);
        idle_gap(2);
        send_packet(20, 1'b0, 1'b1);
        idle_gap(2);
        send_packet(9, 1'b0, 1'b1);
        drain_output();
        check_drops("drop");

        // Random lengths, errors and out_hold
        hold_random = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            send_packet(int'($urandom_range(20, 1)), $urandom_range(7) == 0, 1'b1);
            idle_gap(MAX_GAP);
        end
        hold_random = 1'b0;
        out_hold    = 1'b0;
        drain_output();
        check_drops("random");

        // Overflow with the reader held, model view is exact here
        out_hold = 1'b1;
        next_cycle();
        repeat (5) begin
            send_packet(usb_pkt_pkg::MAX_PKT, 1'b0, 1'b0);
            next_cycle();
        end
        repeat (10) begin
            next_cycle();
            assert (!out_valid) else begin
                ctrl_errs++;
                $display("[ERROR] %0t: output while out_hold is high", $time);
            end
        end
        assert (exp_q.size() == 4 * usb_pkt_pkg::MAX_PKT) else begin
            ctrl_errs++;
            $display("[ERROR] %0t: model accepted %0d bytes in overflow", $time, exp_q.size());
        end
        out_hold = 1'b0;
        drain_output();
        check_drops("overflow");

        // One-byte packets back to back
        for (int n = 0; n < N_SHORT; n++) begin
            send_packet(1, 1'b0, 1'b1);
        end
        drain_output();
        check_drops("short");

        $display("Error counts: data %0d, marker %0d, control %0d",
                 data_errs, marker_errs, ctrl_errs);
        if (data_errs + marker_errs + ctrl_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/usb_ep_buffer_top.sv
// Endpoint packet buffer on one clock. The input has no back-pressure and packets that do not fit are dropped
`timescale 1ns/1ns
`default_nettype none

module usb_ep_buffer_top (
    input  logic                    clk_a,
    input  logic                    rst_a,
    input  logic                    rx_valid,
    input  buf_geom_pkg::buf_data_t rx_data,
    input  logic                    rx_last,
    input  logic                    rx_error,
    input  logic                    out_hold,
    output logic                    out_valid,
    output buf_geom_pkg::buf_data_t out_data,
    output logic                    out_first,
    output logic                    out_last,
    output logic                    pkt_drop
);

    // Writer to buffer
    logic                    wr_en;
    buf_geom_pkg::buf_addr_t wr_addr;
    buf_geom_pkg::buf_data_t wr_data;

    // Writer and reader to length queue
    logic                    push;
    usb_pkt_pkg::pkt_len_t   push_len;
    logic                    pop;
    usb_pkt_pkg::pkt_len_t   head_len;
    logic                    empty;
    logic                    full;

    // Reader and buffer
    logic                    rd_en;
    buf_geom_pkg::buf_addr_t rd_addr;
    buf_geom_pkg::buf_data_t rd_data;
    logic                    rd_valid;
    buf_geom_pkg::buf_addr_t rd_ptr;

    usb_rx_writer u_writer (
        .clk_a    (clk_a),
        .rst_a    (rst_a),
        .rx_valid (rx_valid),
        .rx_last  (rx_last),
        .rx_error (rx_error),
        .rx_data  (rx_data),
        .q_full   (full),
        .rd_ptr   (rd_ptr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .push     (push),
        .push_len (push_len),
        .pkt_drop (pkt_drop)
    );

    usb_dual_port_buffer u_buffer (
        .clk_a    (clk_a),
        .rst_a    (rst_a),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    usb_len_queue u_len_queue (
        .clk_a    (clk_a),
        .rst_a    (rst_a),
        .push     (push),
        .push_len (push_len),
        .pop      (pop),
        .head_len (head_len),
        .empty    (empty),
        .full     (full)
    );

    usb_tx_reader u_reader (
        .clk_a     (clk_a),
        .rst_a     (rst_a),
        .empty     (empty),
        .head_len  (head_len),
        .out_hold  (out_hold),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .pop       (pop),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_ptr    (rd_ptr),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_first (out_first),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

//--- hdl/usb_tx_reader.sv
// System side reader. out_hold stops new reads only, reads already in flight still come out
`timescale 1ns/1ns
`default_nettype none

module usb_tx_reader (
    input  logic                    clk_a,
    input  logic                    rst_a,
    input  logic                    empty,
    input  usb_pkt_pkg::pkt_len_t   head_len,
    input  logic                    out_hold,
    input  buf_geom_pkg::buf_data_t rd_data,
    input  logic                    rd_valid,
    output logic                    pop,
    output logic                    rd_en,
    output buf_geom_pkg::buf_addr_t rd_addr,
    output buf_geom_pkg::buf_addr_t rd_ptr,
    output logic                    out_valid,
    output buf_geom_pkg::buf_data_t out_data,
    output logic                    out_first,
    output logic                    out_last
);

    usb_pkt_pkg::rd_state_t state;
    // Reads still to issue for the current packet
    usb_pkt_pkg::pkt_len_t  remain;
    logic                   first_pend;
    logic                   last_rd;

    // Markers travel beside the read through the buffer's two stages
    logic mk1_first;
    logic mk1_last;
    logic mk2_first;
    logic mk2_last;

    assign pop     = (state == usb_pkt_pkg::RD_IDLE) && !empty && !out_hold;
    assign rd_en   = (state == usb_pkt_pkg::RD_READ) && !out_hold;
    assign rd_addr = rd_ptr;
    assign last_rd = (remain == usb_pkt_pkg::pkt_len_t'(1));

    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            state      <= usb_pkt_pkg::RD_IDLE;
            remain     <= '0;
            first_pend <= 1'b0;
            rd_ptr     <= '0;
        end else begin
            if (pop) begin
                state      <= usb_pkt_pkg::RD_READ;
                remain     <= head_len;
                first_pend <= 1'b1;
            end
            if (rd_en) begin
                rd_ptr     <= rd_ptr + 1'b1;
                remain     <= remain - 1'b1;
                first_pend <= 1'b0;
                if (last_rd) begin
                    state <= usb_pkt_pkg::RD_IDLE;
                end
            end
        end
    end

    // Marker pipeline
    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            mk1_first <= 1'b0;
            mk1_last  <= 1'b0;
            mk2_first <= 1'b0;
            mk2_last  <= 1'b0;
        end else begin
            mk1_first <= rd_en && first_pend;
            mk1_last  <= rd_en && last_rd;
            mk2_first <= mk1_first;
            mk2_last  <= mk1_last;
        end
    end

    // Output straight from the buffer's second stage
    assign out_valid = rd_valid;
    assign out_data  = rd_data;
    assign out_first = mk2_first;
    assign out_last  = mk2_last;

    // Marker pipeline and buffer latency must agree
    a_marker_valid: assert property (
        @(posedge clk_a) disable iff (rst_a)
        (out_first || out_last) |-> out_valid
    ) else $error("packet marker without out_valid");

endmodule

`default_nettype wire

//--- hdl/usb_len_queue.sv
// Circular queue of committed packet lengths. A push while full is ignored
`timescale 1ns/1ns
`default_nettype none

module usb_len_queue (
    input  logic                  clk_a,
    input  logic                  rst_a,
    input  logic                  push,
    input  usb_pkt_pkg::pkt_len_t push_len,
    input  logic                  pop,
    output usb_pkt_pkg::pkt_len_t head_len,
    output logic                  empty,
    output logic                  full
);

    usb_pkt_pkg::pkt_len_t                 slots [usb_pkt_pkg::LEN_SLOTS];
    logic [usb_pkt_pkg::LEN_IDX_W-1:0]     head;
    logic [usb_pkt_pkg::LEN_IDX_W-1:0]     tail;
    logic [usb_pkt_pkg::LEN_CNT_W-1:0]     count;
    logic                                  do_push;
    logic                                  do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Length storage
    always_ff @(posedge clk_a) begin
        if (do_push) begin
            slots[tail] <= push_len;
        end
    end

    // Indices wrap at LEN_SLOTS
    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= tail + 1'b1;
            end
            if (do_pop) begin
                head <= head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head_len = slots[head];
    assign empty    = (count == '0);
    assign full     = (count == usb_pkt_pkg::LEN_CNT_W'(usb_pkt_pkg::LEN_SLOTS));

    // Reader must only pop a committed packet
    a_no_pop_empty: assert property (
        @(posedge clk_a) disable iff (rst_a)
        pop |-> !empty
    ) else $error("pop from an empty length queue");

endmodule

`default_nettype wire

//--- hdl/usb_rx_writer.sv
// Receive side writer. Room and queue slot are checked at the first byte only, no back-pressure
`timescale 1ns/1ns
`default_nettype none

module usb_rx_writer (
    input  logic                    clk_a,
    input  logic                    rst_a,
    input  logic                    rx_valid,
    input  logic                    rx_last,
    input  logic                    rx_error,
    input  buf_geom_pkg::buf_data_t rx_data,
    input  logic                    q_full,
    input  buf_geom_pkg::buf_addr_t rd_ptr,
    output logic                    wr_en,
    output buf_geom_pkg::buf_addr_t wr_addr,
    output buf_geom_pkg::buf_data_t wr_data,
    output logic                    push,
    output usb_pkt_pkg::pkt_len_t   push_len,
    output logic                    pkt_drop
);

    usb_pkt_pkg::wr_state_t  state;
    buf_geom_pkg::buf_addr_t base_ptr;
    buf_geom_pkg::buf_addr_t wr_ptr;
    buf_geom_pkg::buf_addr_t rd_prev;
    buf_geom_pkg::buf_fill_t used;
    buf_geom_pkg::buf_fill_t free_bytes;
    buf_geom_pkg::buf_fill_t used_add;
    buf_geom_pkg::buf_fill_t used_sub;
    usb_pkt_pkg::pkt_len_t   cnt;
    logic                    start_ok;
    logic                    byte_ok;
    logic                    drop_now;

    // Committed bytes not yet read, so free space is unambiguous when the pointers meet
    assign free_bytes = buf_geom_pkg::buf_fill_t'(buf_geom_pkg::DEPTH) - used;
    assign start_ok   = (free_bytes >= buf_geom_pkg::buf_fill_t'(usb_pkt_pkg::MAX_PKT))
                        && !q_full;

    // Whether the current byte may be stored
    always_comb begin
        case (state)
            usb_pkt_pkg::WR_IDLE: byte_ok = start_ok;
            usb_pkt_pkg::WR_RECV: byte_ok = (cnt != usb_pkt_pkg::pkt_len_t'(usb_pkt_pkg::MAX_PKT));
            default:              byte_ok = 1'b0;
        endcase
    end

    assign wr_en    = rx_valid && byte_ok;
    assign wr_addr  = wr_ptr;
    assign wr_data  = rx_data;
    assign push     = wr_en && rx_last && !rx_error;
    assign push_len = (state == usb_pkt_pkg::WR_IDLE) ? usb_pkt_pkg::pkt_len_t'(1)
                                                      : cnt + usb_pkt_pkg::pkt_len_t'(1);

    // Refused first byte, oversize byte, or an error on the last byte
    assign drop_now = rx_valid && (state != usb_pkt_pkg::WR_DROP)
                      && (!byte_ok || (rx_last && rx_error));

    assign used_add = push ? buf_geom_pkg::buf_fill_t'(push_len) : '0;
    // Reader moves at most one byte per cycle
    assign used_sub = (rd_ptr != rd_prev) ? buf_geom_pkg::buf_fill_t'(1) : '0;

    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            state    <= usb_pkt_pkg::WR_IDLE;
            base_ptr <= '0;
            wr_ptr   <= '0;
            rd_prev  <= '0;
            used     <= '0;
            cnt      <= '0;
            pkt_drop <= 1'b0;
        end else begin
            pkt_drop <= drop_now;
            rd_prev  <= rd_ptr;
            used     <= used + used_add - used_sub;
            // Rewind discards everything written since the last commit
            if (drop_now) begin
                wr_ptr <= base_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (push) begin
                base_ptr <= wr_ptr + 1'b1;
            end
            if (wr_en) begin
                cnt <= (state == usb_pkt_pkg::WR_IDLE) ? usb_pkt_pkg::pkt_len_t'(1)
                                                       : cnt + usb_pkt_pkg::pkt_len_t'(1);
            end
            if (rx_valid) begin
                if (rx_last) begin
                    state <= usb_pkt_pkg::WR_IDLE;
                end else if (drop_now) begin
                    state <= usb_pkt_pkg::WR_DROP;
                end else if (wr_en) begin
                    state <= usb_pkt_pkg::WR_RECV;
                end
            end
        end
    end

    // The slot check at the first byte must still hold at commit time
    a_no_push_full: assert property (
        @(posedge clk_a) disable iff (rst_a)
        push |-> !q_full
    ) else $error("length pushed into a full queue");

endmodule

`default_nettype wire

//--- hdl/usb_dual_port_buffer.sv
// Single-clock RAM with write-only port A and read-only port B, two cycles of latency per access
`timescale 1ns/1ns
`default_nettype none

module usb_dual_port_buffer (
    input  logic                    clk_a,
    input  logic                    rst_a,
    // Port A, write side
    input  logic                    wr_en,
    input  buf_geom_pkg::buf_addr_t wr_addr,
    input  buf_geom_pkg::buf_data_t wr_data,
    // Port B, read side
    input  logic                    rd_en,
    input  buf_geom_pkg::buf_addr_t rd_addr,
    output buf_geom_pkg::buf_data_t rd_data,
    output logic                    rd_valid
);

    // Storage array
    buf_geom_pkg::buf_data_t ram [buf_geom_pkg::DEPTH];

    // Stage 1 request registers
    logic                    wr_en_s1;
    buf_geom_pkg::buf_addr_t wr_addr_s1;
    buf_geom_pkg::buf_data_t wr_data_s1;
    logic                    rd_en_s1;
    buf_geom_pkg::buf_addr_t rd_addr_s1;

    // Read and write meet on the same word in stage 1
    logic bypass_hit;

    // Stage 1 strobes
    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            wr_en_s1 <= 1'b0;
            rd_en_s1 <= 1'b0;
        end else begin
            wr_en_s1 <= wr_en;
            rd_en_s1 <= rd_en;
        end
    end

    // Stage 1 addresses and data
    // Only loaded with a live request so idle cycles leave them still
    always_ff @(posedge clk_a) begin
        if (wr_en) begin
            wr_addr_s1 <= wr_addr;
            wr_data_s1 <= wr_data;
        end
        if (rd_en) begin
            rd_addr_s1 <= rd_addr;
        end
    end

    assign bypass_hit = wr_en_s1 && rd_en_s1 && (wr_addr_s1 == rd_addr_s1);

    // Stage 2 array access
    // The array read sees the old word on a same-edge write, hence the bypass
    always_ff @(posedge clk_a) begin
        if (wr_en_s1) begin
            ram[wr_addr_s1] <= wr_data_s1;
        end
        if (rd_en_s1) begin
            if (bypass_hit) begin
                rd_data <= wr_data_s1;
            end else begin
                rd_data <= ram[rd_addr_s1];
            end
        end
    end

    // Stage 2 read strobe
    always_ff @(posedge clk_a) begin
        if (rst_a) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en_s1;
        end
    end

    // Every read returns exactly two cycles after it was requested, and nothing else does
    a_rd_latency: assert property (
        @(posedge clk_a) disable iff (rst_a)
        rd_valid == $past(rd_en, 2)
    ) else $error("rd_valid does not follow rd_en by two cycles");

endmodule

`default_nettype wire

//--- hdl/usb_pkt_pkg.sv
// Packet limits and FSM encodings. LEN_SLOTS must be a power of two for queue index wrap
`default_nettype none

package usb_pkt_pkg;

    // Largest packet the writer accepts, in bytes
    localparam int MAX_PKT = 16;

    // Committed packets that can wait for the reader
    localparam int LEN_SLOTS = 4;

    // Length field holds 1 to MAX_PKT
    localparam int LEN_W = $clog2(MAX_PKT + 1);

    // Queue index and occupancy widths
    localparam int LEN_IDX_W = $clog2(LEN_SLOTS);
    localparam int LEN_CNT_W = $clog2(LEN_SLOTS + 1);

    typedef logic [LEN_W-1:0] pkt_len_t;

    // Writer FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RECV,
        WR_DROP
    } wr_state_t;

    // Reader FSM
    typedef enum logic {
        RD_IDLE,
        RD_READ
    } rd_state_t;

endpackage

`default_nettype wire

//--- hdl/buf_geom_pkg.sv
// Buffer geometry. DEPTH must stay a power of two so that buffer addresses wrap on their own
`default_nettype none

package buf_geom_pkg;

    // One stored packet byte
    localparam int DATA_W = 8;

    // Address width sets the buffer size
    localparam int ADDR_W = 6;
    localparam int DEPTH  = 1 << ADDR_W;

    typedef logic [DATA_W-1:0] buf_data_t;

    // Wraps naturally at DEPTH
    typedef logic [ADDR_W-1:0] buf_addr_t;

    // One extra bit so that a completely full buffer is representable
    typedef logic [ADDR_W:0] buf_fill_t;

endpackage

`default_nettype wire
